// ==== source/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

////////////////////////////////////////
// address split  tag | set | word | byte
////////////////////////////////////////

`define CACHE_ADDR_W        10
`define CACHE_TAG_W         5
`define CACHE_SET_W         1
`define CACHE_NUM_SETS      2
`define CACHE_WORD_OFF_W    2
`define CACHE_BYTE_OFF_W    2

////////////////////////////////////////
// data sizes
////////////////////////////////////////

`define CACHE_LINE_W        128
`define CACHE_WORD_W        32
`define CACHE_BYTE_W        8
`define CACHE_LINE_ADDR_W   6     // tag plus set

// credits held after reset
`define CACHE_CPU_CREDITS   1
`define CACHE_MEM_CREDITS   1

`endif

// ==== source/cachePkg.sv ====
`include "cache_params.svh"

package cachePkg;

    // byte address as seen by the cache
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]      tag;
        logic [`CACHE_SET_W-1:0]      setIdx;
        logic [`CACHE_WORD_OFF_W-1:0] word;
        logic [`CACHE_BYTE_OFF_W-1:0] byteOff;
    } cpuAddr_t;

    typedef struct packed {
        logic                     isWrite;
        cpuAddr_t                 addr;
        logic [`CACHE_BYTE_W-1:0] wrByte;
    } cpuReq_t;

    typedef struct packed {
        logic                     hit;
        logic [`CACHE_WORD_W-1:0] rdWord;
    } cpuResp_t;

    typedef struct packed {
        logic                          isWrite;     // victim write-back
        logic [`CACHE_LINE_ADDR_W-1:0] lineAddr;
        logic [`CACHE_LINE_W-1:0]      line;
    } memReq_t;

    typedef struct packed {
        logic [`CACHE_LINE_W-1:0] line;
    } memResp_t;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`CACHE_TAG_W-1:0]  tag;
        logic [`CACHE_LINE_W-1:0] line;
    } wayLookup_t;

    typedef struct packed {
        logic                                          fill;
        logic                                          byteWrite;
        logic [`CACHE_SET_W-1:0]                       setIdx;
        logic [`CACHE_TAG_W-1:0]                       tag;
        logic [`CACHE_LINE_W-1:0]                      line;
        logic [`CACHE_WORD_OFF_W+`CACHE_BYTE_OFF_W-1:0] lane;  // byte offset in line
        logic [`CACHE_BYTE_W-1:0]                      byteVal;
    } wayUpdate_t;

endpackage

// ==== source/cacheWay.sv ====
`timescale 1ns/100ps
`include "cache_params.svh"

module cacheWay
    import cachePkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`CACHE_SET_W-1:0] lookupSet,
    input  logic [`CACHE_TAG_W-1:0] lookupTag,
    input  wayUpdate_t              update,
    output wayLookup_t              lookup,
    output logic                    tagMatch
);

    localparam int LaneW = `CACHE_WORD_OFF_W + `CACHE_BYTE_OFF_W;

    logic                     validBits [`CACHE_NUM_SETS];
    logic                     dirtyBits [`CACHE_NUM_SETS];
    logic [`CACHE_TAG_W-1:0]  tagMem    [`CACHE_NUM_SETS];
    logic [`CACHE_LINE_W-1:0] lineMem   [`CACHE_NUM_SETS];
    logic [LaneW-1:0]         laneShift;

    assign laneShift = ~update.lane; // offset 0 is the msb byte

    ////////////////////////////////////////
    // state bits
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
                validBits[s] <= 1'b0;
                dirtyBits[s] <= 1'b0;
            end
        end else if (update.fill) begin
            validBits[update.setIdx] <= 1'b1;
            dirtyBits[update.setIdx] <= 1'b0; // same as memory now
        end else if (update.byteWrite) begin
            dirtyBits[update.setIdx] <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // tag and data
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (update.fill) begin
            tagMem[update.setIdx]  <= update.tag;
            lineMem[update.setIdx] <= update.line;
        end else if (update.byteWrite) begin
            lineMem[update.setIdx][laneShift*`CACHE_BYTE_W +: `CACHE_BYTE_W] <= update.byteVal;
        end
    end

    // addressed set, straight from the registers
    always_comb begin
        lookup.valid = validBits[lookupSet];
        lookup.dirty = dirtyBits[lookupSet];
        lookup.tag   = tagMem[lookupSet];
        lookup.line  = lineMem[lookupSet];
    end

    assign tagMatch = lookup.valid && (lookup.tag == lookupTag);

endmodule

// ==== source/cacheController.sv ====
`timescale 1ns/100ps
`include "cache_params.svh"

module cacheController
    import cachePkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    // cpu side
    input  logic                    cpuReqValid,
    input  cpuReq_t                 cpuReq,
    output logic                    cpuRespValid,
    output cpuResp_t                cpuResp,
    output logic                    cpuCredit,
    // memory side
    output logic                    memReqValid,
    output memReq_t                 memReq,
    input  logic                    memRespValid,
    input  memResp_t                memResp,
    input  logic                    memCredit,
    // ways
    input  wayLookup_t              way0Lookup,
    input  wayLookup_t              way1Lookup,
    input  logic                    way0Match,
    input  logic                    way1Match,
    output logic [`CACHE_SET_W-1:0] lookupSet,
    output logic [`CACHE_TAG_W-1:0] lookupTag,
    output wayUpdate_t              way0Update,
    output wayUpdate_t              way1Update
);

    localparam int MemCreditW = $clog2(`CACHE_MEM_CREDITS + 1);

    typedef enum logic [2:0] {
        stIdle,
        stLookup,
        stWriteBack,
        stRefill,
        stRespond
    } ctrlState_t;

    ctrlState_t                    state;
    cpuReq_t                       req;        // held request
    logic                          missed;
    logic                          memIssued;  // current mem op already sent
    logic [`CACHE_NUM_SETS-1:0]    lruVictim;
    logic [MemCreditW-1:0]         memCredits;

    logic                          hit;
    logic                          hitWay;
    logic                          victimWay;
    logic                          memIssue;
    logic                          targetWay;
    wayLookup_t                    hitLookup;
    wayLookup_t                    victimLookup;
    wayUpdate_t                    upd;
    logic [`CACHE_WORD_OFF_W-1:0]  wordShift;
    logic [`CACHE_WORD_W-1:0]      readWord;

    assign lookupSet = req.addr.setIdx;
    assign lookupTag = req.addr.tag;

    ////////////////////////////////////////
    // lookup combine
    ////////////////////////////////////////

    assign hit       = way0Match | way1Match;
    assign hitWay    = way1Match;
    assign victimWay = lruVictim[req.addr.setIdx]; // steady for the whole miss

    assign hitLookup    = hitWay ? way1Lookup : way0Lookup;
    assign victimLookup = victimWay ? way1Lookup : way0Lookup;

    assign wordShift = ~req.addr.word; // word 0 at the msb end
    assign readWord  = hitLookup.line[wordShift*`CACHE_WORD_W +: `CACHE_WORD_W];

    assign memIssue = ((state == stWriteBack) || (state == stRefill)) &&
                      !memIssued && (memCredits != '0);

    assign cpuCredit = cpuRespValid; // one credit back per response

    ////////////////////////////////////////
    // way updates
    ////////////////////////////////////////

    always_comb begin
        upd.fill      = (state == stRefill) && memIssued && memRespValid;
        upd.byteWrite = (state == stLookup) && hit && req.isWrite;
        upd.setIdx    = req.addr.setIdx;
        upd.tag       = req.addr.tag;
        upd.line      = memResp.line;
        upd.lane      = {req.addr.word, req.addr.byteOff};
        upd.byteVal   = req.wrByte;

        targetWay  = upd.fill ? victimWay : hitWay;
        way0Update = upd;
        way1Update = upd;
        if (targetWay) begin
            way0Update.fill      = 1'b0;
            way0Update.byteWrite = 1'b0;
        end else begin
            way1Update.fill      = 1'b0;
            way1Update.byteWrite = 1'b0;
        end
    end

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= stIdle;
            missed       <= 1'b0;
            memIssued    <= 1'b0;
            lruVictim    <= '0;   // way 0 goes first
            memCredits   <= MemCreditW'(`CACHE_MEM_CREDITS);
            cpuRespValid <= 1'b0;
            memReqValid  <= 1'b0;
        end else begin
            cpuRespValid <= 1'b0;
            memReqValid  <= memIssue;
            memCredits   <= memCredits + MemCreditW'(memCredit) - MemCreditW'(memIssue);

            case (state)
                stIdle: begin
                    if (cpuReqValid) begin
                        missed <= 1'b0;
                        state  <= stLookup;
                    end
                end
                stLookup: begin
                    if (hit) begin
                        lruVictim[req.addr.setIdx] <= ~hitWay;
                        cpuRespValid               <= 1'b1;
                        state                      <= stRespond;
                    end else begin
                        missed    <= 1'b1;
                        memIssued <= 1'b0;
                        if (victimLookup.valid && victimLookup.dirty) begin
                            state <= stWriteBack;
                        end else begin
                            state <= stRefill;
                        end
                    end
                end
                stWriteBack: begin
                    if (memIssue) begin
                        memIssued <= 1'b1;
                    end else if (memIssued && memCredit) begin // write committed
                        memIssued <= 1'b0;
                        state     <= stRefill;
                    end
                end
                stRefill: begin
                    if (memIssue) begin
                        memIssued <= 1'b1;
                    end else if (memIssued && memRespValid) begin
                        memIssued <= 1'b0;
                        state     <= stLookup; // now hits, merge happens there
                    end
                end
                stRespond: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if ((state == stIdle) && cpuReqValid) begin
            req <= cpuReq;
        end
        if ((state == stLookup) && hit) begin
            cpuResp.hit    <= !missed;
            cpuResp.rdWord <= readWord;
        end
        if (memIssue) begin
            memReq.isWrite <= (state == stWriteBack);
            if (state == stWriteBack) begin
                memReq.lineAddr <= {victimLookup.tag, req.addr.setIdx}; // victim's own line
            end else begin
                memReq.lineAddr <= {req.addr.tag, req.addr.setIdx};
            end
            memReq.line <= victimLookup.line;
        end
    end

endmodule

// ==== source/cacheTop.sv ====
`timescale 1ns/100ps
`include "cache_params.svh"

module cacheTop
    import cachePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // cpu side
    input  logic     cpuReqValid,
    input  cpuReq_t  cpuReq,
    output logic     cpuRespValid,
    output cpuResp_t cpuResp,
    output logic     cpuCredit,
    // memory side
    output logic     memReqValid,
    output memReq_t  memReq,
    input  logic     memRespValid,
    input  memResp_t memResp,
    input  logic     memCredit
);

    wayLookup_t              way0Lookup;
    wayLookup_t              way1Lookup;
    wayUpdate_t              way0Update;
    wayUpdate_t              way1Update;
    logic                    way0Match;
    logic                    way1Match;
    logic [`CACHE_SET_W-1:0] lookupSet;
    logic [`CACHE_TAG_W-1:0] lookupTag;

    cacheWay way0_i (
        .clk       (clk),
        .rst       (rst),
        .lookupSet (lookupSet),
        .lookupTag (lookupTag),
        .update    (way0Update),
        .lookup    (way0Lookup),
        .tagMatch  (way0Match)
    );

    cacheWay way1_i (
        .clk       (clk),
        .rst       (rst),
        .lookupSet (lookupSet),
        .lookupTag (lookupTag),
        .update    (way1Update),
        .lookup    (way1Lookup),
        .tagMatch  (way1Match)
    );

    cacheController ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .cpuReqValid  (cpuReqValid),
        .cpuReq       (cpuReq),
        .cpuRespValid (cpuRespValid),
        .cpuResp      (cpuResp),
        .cpuCredit    (cpuCredit),
        .memReqValid  (memReqValid),
        .memReq       (memReq),
        .memRespValid (memRespValid),
        .memResp      (memResp),
        .memCredit    (memCredit),
        .way0Lookup   (way0Lookup),
        .way1Lookup   (way1Lookup),
        .way0Match    (way0Match),
        .way1Match    (way1Match),
        .lookupSet    (lookupSet),
        .lookupTag    (lookupTag),
        .way0Update   (way0Update),
        .way1Update   (way1Update)
    );

endmodule

// ==== dv/lineMemoryModel.sv ====
`timescale 1ns/100ps
`include "cache_params.svh"

module lineMemoryModel
    import cachePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     memReqValid,
    input  memReq_t  memReq,
    output logic     memRespValid,
    output memResp_t memResp,
    output logic     memCredit
);

    localparam int NumBytes  = 1 << `CACHE_ADDR_W;
    localparam int LineBytes = `CACHE_LINE_W / `CACHE_BYTE_W;

    logic [`CACHE_BYTE_W-1:0] memBytes [NumBytes];
    logic [15:0]              lfsr;
    memReq_t                  pending;
    logic                     busy;
    logic [2:0]               waitLeft;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] patternByte(input int a);
        logic [`CACHE_ADDR_W-1:0] addr;
        addr = `CACHE_ADDR_W'(a);
        return 8'(7 * a + 3) ^ {addr[9:8], 6'b0}; // top bits keep aliases apart
    endfunction

    function automatic logic [`CACHE_LINE_W-1:0] readLine(input logic [5:0] la);
        logic [`CACHE_LINE_W-1:0] line;
        for (int k = 0; k < LineBytes; k++) begin
            line[(LineBytes-1-k)*8 +: 8] = memBytes[int'(la) * LineBytes + k];
        end
        return line;
    endfunction

    initial begin
        memRespValid <= 1'b0;
        memCredit    <= 1'b0;
        memResp      <= '0;
        for (int a = 0; a < NumBytes; a++) begin
            memBytes[a] = patternByte(a);
        end
    end

    always @(posedge clk) begin : memSeq
        logic [15:0] s;
        logic [1:0]  draw;
        int          base;
        if (rst) begin
            lfsr         <= 16'd4912;
            busy         <= 1'b0;
            waitLeft     <= '0;
            memRespValid <= 1'b0;
            memCredit    <= 1'b0;
            memResp      <= '0;
        end else begin
            memRespValid <= 1'b0;
            memCredit    <= 1'b0;
            if (memReqValid && !busy) begin
                s = lfsr;
                for (int b = 0; b < 2; b++) begin
                    s       = lfsrStep(s);
                    draw[b] = s[0];
                end
                lfsr     <= s;
                pending  <= memReq;
                waitLeft <= 3'(draw) + 3'd1; // 1 to 4 cycles
                busy     <= 1'b1;
            end else if (busy) begin
                if (waitLeft == 3'd1) begin
                    busy      <= 1'b0;
                    memCredit <= 1'b1;
                    base = int'(pending.lineAddr) * LineBytes;
                    if (pending.isWrite) begin
                        for (int k = 0; k < LineBytes; k++) begin
                            memBytes[base + k] <= pending.line[(LineBytes-1-k)*8 +: 8];
                        end
                    end else begin
                        memRespValid <= 1'b1;
                        memResp.line <= readLine(pending.lineAddr);
                    end
                end else begin
                    waitLeft <= waitLeft - 3'd1;
                end
            end
        end
    end

endmodule

// ==== dv/cacheTb.sv ====
`timescale 1ns/100ps
`include "cache_params.svh"

module cacheTb
    import cachePkg::*;
;

    typedef struct packed {
        logic                          isWrite;
        logic [`CACHE_ADDR_W-1:0]      addr;
        logic [`CACHE_BYTE_W-1:0]      wrByte;
        logic                          expHit;
        logic                          expWb;
        logic [`CACHE_LINE_ADDR_W-1:0] wbLine;   // victim line, when expWb
    } stimEntry_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     cpuReqValid;
    cpuReq_t  cpuReq;
    logic     cpuRespValid;
    cpuResp_t cpuResp;
    logic     cpuCredit;
    logic     memReqValid;
    memReq_t  memReq;
    logic     memRespValid;
    memResp_t memResp;
    logic     memCredit;

    stimEntry_t               stimTable [$];
    memReq_t                  memLog [$];
    logic [`CACHE_BYTE_W-1:0] shadow [1 << `CACHE_ADDR_W];
    int                       creditsReturned = 0;
    int                       responsesSeen = 0;
    int                       tableLen = 0;

    always #4 clk = ~clk;

    cacheTop dut_i (
        .clk          (clk),
        .rst          (rst),
        .cpuReqValid  (cpuReqValid),
        .cpuReq       (cpuReq),
        .cpuRespValid (cpuRespValid),
        .cpuResp      (cpuResp),
        .cpuCredit    (cpuCredit),
        .memReqValid  (memReqValid),
        .memReq       (memReq),
        .memRespValid (memRespValid),
        .memResp      (memResp),
        .memCredit    (memCredit)
    );

    lineMemoryModel mem_i (
        .clk          (clk),
        .rst          (rst),
        .memReqValid  (memReqValid),
        .memReq       (memReq),
        .memRespValid (memRespValid),
        .memResp      (memResp),
        .memCredit    (memCredit)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic checkValue(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = %0h, expected %0h", name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic addEntry(input logic w, input logic [9:0] a, input logic [7:0] b,
                            input logic h, input logic wb, input logic [5:0] wl);
        stimEntry_t e;
        e.isWrite = w;
        e.addr    = a;
        e.wrByte  = b;
        e.expHit  = h;
        e.expWb   = wb;
        e.wbLine  = wl;
        stimTable.push_back(e);
    endtask

    // same fill rule as the memory model
    function automatic logic [7:0] initByte(input int a);
        logic [9:0] addr;
        addr = 10'(a);
        return 8'(7 * a + 3) ^ {addr[9:8], 6'b0};
    endfunction

    // offset 0 sits in the msb byte
    function automatic logic [31:0] shadowWord(input logic [9:0] a);
        int base;
        base = int'({a[9:2], 2'b00});
        return {shadow[base], shadow[base + 1], shadow[base + 2], shadow[base + 3]};
    endfunction

    function automatic logic [127:0] shadowLine(input logic [5:0] la);
        logic [127:0] line;
        for (int k = 0; k < 16; k++) begin
            line[(15-k)*8 +: 8] = shadow[int'(la) * 16 + k];
        end
        return line;
    endfunction

    task automatic buildTable();
        // set 0 and set 1 cold, then hits and a byte write
        addEntry(1'b0, 10'h000, 8'h00, 1'b0, 1'b0, 6'h00);
        addEntry(1'b0, 10'h014, 8'h00, 1'b0, 1'b0, 6'h00);
        addEntry(1'b0, 10'h004, 8'h00, 1'b1, 1'b0, 6'h00);
        addEntry(1'b0, 10'h01C, 8'h00, 1'b1, 1'b0, 6'h00);
        addEntry(1'b1, 10'h005, 8'hA5, 1'b1, 1'b0, 6'h00);
        addEntry(1'b0, 10'h004, 8'h00, 1'b1, 1'b0, 6'h00);
        // third tag in set 0
        addEntry(1'b0, 10'h020, 8'h00, 1'b0, 1'b0, 6'h00);
        addEntry(1'b0, 10'h000, 8'h00, 1'b1, 1'b0, 6'h00);
        addEntry(1'b0, 10'h048, 8'h00, 1'b0, 1'b0, 6'h00); // clean evict of line 02
        addEntry(1'b0, 10'h008, 8'h00, 1'b1, 1'b0, 6'h00);
        addEntry(1'b0, 10'h04C, 8'h00, 1'b1, 1'b0, 6'h00);
        addEntry(1'b0, 10'h060, 8'h00, 1'b0, 1'b1, 6'h00); // dirty line 00 out
        addEntry(1'b0, 10'h004, 8'h00, 1'b0, 1'b0, 6'h00);
        // write miss, later eviction
        addEntry(1'b1, 10'h0A3, 8'h3C, 1'b0, 1'b0, 6'h00);
        addEntry(1'b0, 10'h0A0, 8'h00, 1'b1, 1'b0, 6'h00);
        addEntry(1'b0, 10'h080, 8'h00, 1'b0, 1'b0, 6'h00);
        addEntry(1'b0, 10'h0C0, 8'h00, 1'b0, 1'b1, 6'h0A);
        addEntry(1'b0, 10'h0A0, 8'h00, 1'b0, 1'b0, 6'h00);
        // set 1
        addEntry(1'b1, 10'h11A, 8'h5E, 1'b0, 1'b0, 6'h00);
        addEntry(1'b0, 10'h018, 8'h00, 1'b1, 1'b0, 6'h00);
        addEntry(1'b0, 10'h318, 8'h00, 1'b0, 1'b1, 6'h11);
        addEntry(1'b0, 10'h118, 8'h00, 1'b0, 1'b0, 6'h00);
        addEntry(1'b1, 10'h3F7, 8'hC3, 1'b0, 1'b0, 6'h00);
        addEntry(1'b0, 10'h3F4, 8'h00, 1'b1, 1'b0, 6'h00);
        addEntry(1'b0, 10'h210, 8'h00, 1'b0, 1'b0, 6'h00);
        addEntry(1'b0, 10'h014, 8'h00, 1'b0, 1'b1, 6'h3F);
        addEntry(1'b0, 10'h3F4, 8'h00, 1'b0, 1'b0, 6'h00);
    endtask

    ////////////////////////////////////////
    // monitors
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            if (cpuCredit) begin
                creditsReturned <= creditsReturned + 1;
            end
            if (cpuRespValid) begin
                responsesSeen <= responsesSeen + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && memReqValid) begin
            memLog.push_back(memReq);
        end
    end

    initial begin : watchdog
        wait (tableLen != 0);
        repeat (tableLen * 40 + 100) @(posedge clk);
        $display("Timeout: the cache did not finish the table in %0d cycles",
                 tableLen * 40 + 100);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin : mainSeq
        stimEntry_t e;
        cpuReq_t    r;
        int         n;
        int         sent;
        int         logStart;
        int         expOps;
        rst         = 1'b1;
        cpuReqValid = 1'b0;
        cpuReq      = '0;
        sent        = 0;
        for (int a = 0; a < (1 << `CACHE_ADDR_W); a++) begin
            shadow[a] = initByte(a);
        end
        buildTable();
        tableLen = stimTable.size();

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < tableLen; i++) begin
            e = stimTable[i];
            @(posedge clk);
            while (`CACHE_CPU_CREDITS + creditsReturned - sent <= 0) begin
                @(posedge clk);
            end
            r.isWrite = e.isWrite;
            r.addr    = cpuAddr_t'(e.addr);
            r.wrByte  = e.wrByte;
            cpuReqValid <= 1'b1;
            cpuReq      <= r;
            sent++;
            logStart = memLog.size();
            @(posedge clk);
            cpuReqValid <= 1'b0;   // sampled at this edge
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (cpuRespValid !== 1'b1);

            // one credit and one response for each earlier request
            checkValue("cpuCredit", cpuCredit, 1'b1);
            checkValue("cpuCredit pulses", creditsReturned, i);
            checkValue("cpuRespValid pulses", responsesSeen, i);
            checkValue("cpuResp.hit", cpuResp.hit, e.expHit);
            if (e.expHit) begin
                checkValue("hit latency", n, 2);
            end
            if (!e.isWrite) begin
                checkValue("cpuResp.rdWord", cpuResp.rdWord, shadowWord(e.addr));
            end
            expOps = e.expHit ? 0 : (e.expWb ? 2 : 1);
            checkValue("memory request count", memLog.size() - logStart, expOps);
            if (e.expWb) begin
                // write-back goes first
                checkValue("memReq.isWrite", memLog[logStart].isWrite, 1'b1);
                checkValue("memReq.lineAddr", memLog[logStart].lineAddr, e.wbLine);
                checkValue("memReq.line", memLog[logStart].line, shadowLine(e.wbLine));
            end
            if (!e.expHit) begin
                checkValue("memReq.isWrite", memLog[memLog.size() - 1].isWrite, 1'b0);
                checkValue("memReq.lineAddr", memLog[memLog.size() - 1].lineAddr,
                           e.addr[9:4]);
            end
            if (e.isWrite) begin
                shadow[e.addr] = e.wrByte;
            end
        end

        repeat (4) @(posedge clk);
        checkValue("cpuCredit pulses", creditsReturned, tableLen);
        checkValue("cpuRespValid pulses", responsesSeen, tableLen);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+source
source/cachePkg.sv
source/cacheWay.sv
source/cacheController.sv
source/cacheTop.sv
dv/lineMemoryModel.sv
dv/cacheTb.sv
